/* common/l15_defs.svh */
`ifndef L15_DEFS_SVH
`define L15_DEFS_SVH

// Physical address width of the L1.5 request bus
`define L15_PADDR_WIDTH 40

// One data word on either direction of the L1.5 interface
`define L15_DWORD_WIDTH 64

// Per-engine request queue depth
`define L15_REQ_FIFO_ELS 2

// Return queue depth, sized for the L1.5 outstanding returns
`define L15_RET_FIFO_ELS 16

`endif

/* common/l15_pkg.sv */
`include "l15_defs.svh"

package l15_pkg;

  // Request types as driven on transducer_l15_rqtype
  typedef enum logic [4:0] {
    e_load_rq  = 5'b00000,
    e_store_rq = 5'b00001,
    e_amo_rq   = 5'b00110,
    e_imiss_rq = 5'b10000
  } l15_rqtype_e;

  // Return types as seen on l15_transducer_returntype
  typedef enum logic [3:0] {
    e_load_ret   = 4'b0000,
    e_ifill_ret  = 4'b0001,
    e_evict_req  = 4'b0011,
    e_st_ack     = 4'b0100,
    e_int_ret    = 4'b0111,
    e_atomic_ret = 4'b1101
  } l15_rtntype_e;

  typedef struct packed {
    l15_rqtype_e                  rqtype;
    logic                         nc;
    logic [2:0]                   size;
    logic [`L15_PADDR_WIDTH-1:0]  address;
    logic [`L15_DWORD_WIDTH-1:0]  data;
    logic [1:0]                   l1rplway;
    logic [3:0]                   amo_op;
  } l15_req_s;

  // Full cache line return, four data words
  typedef struct packed {
    l15_rtntype_e                 rtntype;
    logic                         noncacheable;
    logic                         atomic;
    logic [`L15_DWORD_WIDTH-1:0]  data_0;
    logic [`L15_DWORD_WIDTH-1:0]  data_1;
    logic [`L15_DWORD_WIDTH-1:0]  data_2;
    logic [`L15_DWORD_WIDTH-1:0]  data_3;
  } l15_ret_s;

endpackage

/* design/l15_fifo.sv */
`include "l15_defs.svh"

module l15_fifo
  import l15_pkg::*;
  #(parameter type payload_t = l15_req_s
    , parameter int els_p = `L15_REQ_FIFO_ELS
    )
  (input                clk_i
   , input              arst_n_i

   , input payload_t    data_i
   , input              v_i
   , output logic       ready_o

   , output payload_t   data_o
   , output logic       v_o
   , input              yumi_i
   );

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  payload_t                 mem_r [els_p];
  logic [ptr_width_lp-1:0]  wptr_r, rptr_r;
  logic [cnt_width_lp-1:0]  count_r;
  logic                     push_li, pop_li;

  assign ready_o = (count_r != cnt_width_lp'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];

  assign push_li = v_i & ready_o;
  // Consumer only yumis a valid head
  assign pop_li  = yumi_i;

  always_ff @(posedge clk_i) begin
    if (push_li) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push_li) begin
        if (wptr_r == ptr_width_lp'(els_p - 1)) begin
          wptr_r <= '0;
        end else begin
          wptr_r <= wptr_r + 1'b1;
        end
      end

      if (pop_li) begin
        if (rptr_r == ptr_width_lp'(els_p - 1)) begin
          rptr_r <= '0;
        end else begin
          rptr_r <= rptr_r + 1'b1;
        end
      end

      // Simultaneous push and pop leaves occupancy unchanged
      case ({push_li, pop_li})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

/* l15_bridge/l15_req_arbiter.sv */
`include "l15_defs.svh"

module l15_req_arbiter
  import l15_pkg::*;
  (input                clk_i
   , input              arst_n_i

   , input l15_req_s    icache_req_i
   , input              icache_req_v_i
   , output logic       icache_req_ready_o

   , input l15_req_s    dcache_req_i
   , input              dcache_req_v_i
   , output logic       dcache_req_ready_o

   , output l15_req_s   l15_req_o
   , output logic       l15_val_o
   , input              l15_ack_i
   );

  l15_req_s icache_fifo_lo, dcache_fifo_lo;
  logic     icache_fifo_v_lo, dcache_fifo_v_lo;
  logic     icache_fifo_yumi_li, dcache_fifo_yumi_li;
  logic     icache_grant_lo, dcache_grant_lo;

  l15_fifo
   #(.payload_t(l15_req_s)
     ,.els_p(`L15_REQ_FIFO_ELS)
     )
   icache_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.data_i(icache_req_i)
     ,.v_i(icache_req_v_i)
     ,.ready_o(icache_req_ready_o)

     ,.data_o(icache_fifo_lo)
     ,.v_o(icache_fifo_v_lo)
     ,.yumi_i(icache_fifo_yumi_li)
     );

  l15_fifo
   #(.payload_t(l15_req_s)
     ,.els_p(`L15_REQ_FIFO_ELS)
     )
   dcache_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.data_i(dcache_req_i)
     ,.v_i(dcache_req_v_i)
     ,.ready_o(dcache_req_ready_o)

     ,.data_o(dcache_fifo_lo)
     ,.v_o(dcache_fifo_v_lo)
     ,.yumi_i(dcache_fifo_yumi_li)
     );

  // Fixed priority, data side first
  assign dcache_grant_lo = dcache_fifo_v_lo;
  assign icache_grant_lo = icache_fifo_v_lo & ~dcache_fifo_v_lo;

  assign l15_val_o = icache_grant_lo | dcache_grant_lo;
  assign l15_req_o = dcache_grant_lo ? dcache_fifo_lo : icache_fifo_lo;

  // Granted head leaves when the L1.5 takes it
  assign icache_fifo_yumi_li = icache_grant_lo & l15_ack_i;
  assign dcache_fifo_yumi_li = dcache_grant_lo & l15_ack_i;

endmodule

/* l15_bridge/l15_ret_router.sv */
`include "l15_defs.svh"

module l15_ret_router
  import l15_pkg::*;
  (input                clk_i
   , input              arst_n_i

   , input l15_ret_s    ret_i
   , input              ret_v_i
   , output logic       ret_ack_o

   , output l15_ret_s   ret_o
   , output logic       icache_ret_v_o
   , output logic       dcache_ret_v_o
   , input              icache_ret_yumi_i
   , input              dcache_ret_yumi_i
   );

  logic     fifo_ready_lo;
  logic     fifo_v_lo;
  logic     fifo_yumi_li;
  l15_ret_s fifo_lo;

  l15_fifo
   #(.payload_t(l15_ret_s)
     ,.els_p(`L15_RET_FIFO_ELS)
     )
   ret_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.data_i(ret_i)
     ,.v_i(ret_v_i)
     ,.ready_o(fifo_ready_lo)

     ,.data_o(fifo_lo)
     ,.v_o(fifo_v_lo)
     ,.yumi_i(fifo_yumi_li)
     );

  // L1.5 holds its valid until we ack
  assign ret_ack_o = fifo_ready_lo & ret_v_i;

  assign ret_o = fifo_lo;

  always_comb begin
    icache_ret_v_o = 1'b0;
    dcache_ret_v_o = 1'b0;

    // Loads and store acks belong to the data side only
    if ((fifo_lo.rtntype != e_load_ret) && (fifo_lo.rtntype != e_st_ack)) begin
      icache_ret_v_o = fifo_v_lo;
    end

    // Everything but instruction fills reaches the data side
    if (fifo_lo.rtntype != e_ifill_ret) begin
      dcache_ret_v_o = fifo_v_lo;
    end
  end

  // Shared entries leave on the first taker
  assign fifo_yumi_li = icache_ret_yumi_i | dcache_ret_yumi_i;

endmodule

/* l15_bridge/l15_bridge_top.sv */
`include "l15_defs.svh"

module l15_bridge_top
  import l15_pkg::*;
  (input                                     clk_i
   , input                                   arst_n_i

   // Instruction cache engine requests
   , input                                   icache_req_v_i
   , input [4:0]                             icache_req_rqtype_i
   , input                                   icache_req_nc_i
   , input [2:0]                             icache_req_size_i
   , input [`L15_PADDR_WIDTH-1:0]            icache_req_address_i
   , input [`L15_DWORD_WIDTH-1:0]            icache_req_data_i
   , input [1:0]                             icache_req_l1rplway_i
   , input [3:0]                             icache_req_amo_op_i
   , output logic                            icache_req_ready_o

   // Data cache engine requests
   , input                                   dcache_req_v_i
   , input [4:0]                             dcache_req_rqtype_i
   , input                                   dcache_req_nc_i
   , input [2:0]                             dcache_req_size_i
   , input [`L15_PADDR_WIDTH-1:0]            dcache_req_address_i
   , input [`L15_DWORD_WIDTH-1:0]            dcache_req_data_i
   , input [1:0]                             dcache_req_l1rplway_i
   , input [3:0]                             dcache_req_amo_op_i
   , output logic                            dcache_req_ready_o

   // Transducer -> L1.5
   , output logic                            transducer_l15_val_o
   , output logic [4:0]                      transducer_l15_rqtype_o
   , output logic                            transducer_l15_nc_o
   , output logic [2:0]                      transducer_l15_size_o
   , output logic [`L15_PADDR_WIDTH-1:0]     transducer_l15_address_o
   , output logic [`L15_DWORD_WIDTH-1:0]     transducer_l15_data_o
   , output logic [1:0]                      transducer_l15_l1rplway_o
   , output logic [3:0]                      transducer_l15_amo_op_o
   , input                                   l15_transducer_ack_i

   // L1.5 -> transducer
   , input                                   l15_transducer_val_i
   , input [3:0]                             l15_transducer_returntype_i
   , input                                   l15_transducer_noncacheable_i
   , input                                   l15_transducer_atomic_i
   , input [`L15_DWORD_WIDTH-1:0]            l15_transducer_data_0_i
   , input [`L15_DWORD_WIDTH-1:0]            l15_transducer_data_1_i
   , input [`L15_DWORD_WIDTH-1:0]            l15_transducer_data_2_i
   , input [`L15_DWORD_WIDTH-1:0]            l15_transducer_data_3_i
   , output logic                            transducer_l15_req_ack_o

   // Returns toward the cache engines
   , output logic [3:0]                      ret_rtntype_o
   , output logic                            ret_noncacheable_o
   , output logic                            ret_atomic_o
   , output logic [`L15_DWORD_WIDTH-1:0]     ret_data_0_o
   , output logic [`L15_DWORD_WIDTH-1:0]     ret_data_1_o
   , output logic [`L15_DWORD_WIDTH-1:0]     ret_data_2_o
   , output logic [`L15_DWORD_WIDTH-1:0]     ret_data_3_o
   , output logic                            icache_ret_v_o
   , output logic                            dcache_ret_v_o
   , input                                   icache_ret_yumi_i
   , input                                   dcache_ret_yumi_i
   );

  l15_req_s icache_req_li, dcache_req_li, l15_req_lo;
  l15_ret_s l15_ret_li, ret_lo;

  assign icache_req_li = '{rqtype:   l15_rqtype_e'(icache_req_rqtype_i)
                          ,nc:       icache_req_nc_i
                          ,size:     icache_req_size_i
                          ,address:  icache_req_address_i
                          ,data:     icache_req_data_i
                          ,l1rplway: icache_req_l1rplway_i
                          ,amo_op:   icache_req_amo_op_i
                          };

  assign dcache_req_li = '{rqtype:   l15_rqtype_e'(dcache_req_rqtype_i)
                          ,nc:       dcache_req_nc_i
                          ,size:     dcache_req_size_i
                          ,address:  dcache_req_address_i
                          ,data:     dcache_req_data_i
                          ,l1rplway: dcache_req_l1rplway_i
                          ,amo_op:   dcache_req_amo_op_i
                          };

  l15_req_arbiter
   req_arbiter
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.icache_req_i(icache_req_li)
     ,.icache_req_v_i(icache_req_v_i)
     ,.icache_req_ready_o(icache_req_ready_o)

     ,.dcache_req_i(dcache_req_li)
     ,.dcache_req_v_i(dcache_req_v_i)
     ,.dcache_req_ready_o(dcache_req_ready_o)

     ,.l15_req_o(l15_req_lo)
     ,.l15_val_o(transducer_l15_val_o)
     ,.l15_ack_i(l15_transducer_ack_i)
     );

  assign transducer_l15_rqtype_o   = l15_req_lo.rqtype;
  assign transducer_l15_nc_o       = l15_req_lo.nc;
  assign transducer_l15_size_o     = l15_req_lo.size;
  assign transducer_l15_address_o  = l15_req_lo.address;
  assign transducer_l15_data_o     = l15_req_lo.data;
  assign transducer_l15_l1rplway_o = l15_req_lo.l1rplway;
  assign transducer_l15_amo_op_o   = l15_req_lo.amo_op;

  assign l15_ret_li = '{rtntype:      l15_rtntype_e'(l15_transducer_returntype_i)
                       ,noncacheable: l15_transducer_noncacheable_i
                       ,atomic:       l15_transducer_atomic_i
                       ,data_0:       l15_transducer_data_0_i
                       ,data_1:       l15_transducer_data_1_i
                       ,data_2:       l15_transducer_data_2_i
                       ,data_3:       l15_transducer_data_3_i
                       };

  l15_ret_router
   ret_router
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)

     ,.ret_i(l15_ret_li)
     ,.ret_v_i(l15_transducer_val_i)
     ,.ret_ack_o(transducer_l15_req_ack_o)

     ,.ret_o(ret_lo)
     ,.icache_ret_v_o(icache_ret_v_o)
     ,.dcache_ret_v_o(dcache_ret_v_o)
     ,.icache_ret_yumi_i(icache_ret_yumi_i)
     ,.dcache_ret_yumi_i(dcache_ret_yumi_i)
     );

  // Both engines see the same head fields
  assign ret_rtntype_o      = ret_lo.rtntype;
  assign ret_noncacheable_o = ret_lo.noncacheable;
  assign ret_atomic_o       = ret_lo.atomic;
  assign ret_data_0_o       = ret_lo.data_0;
  assign ret_data_1_o       = ret_lo.data_1;
  assign ret_data_2_o       = ret_lo.data_2;
  assign ret_data_3_o       = ret_lo.data_3;

endmodule

/* tests/tb_l15_bridge.sv */
`include "l15_defs.svh"

module tb_l15_bridge;

  localparam int req_w_lp = 5 + 1 + 3 + `L15_PADDR_WIDTH + `L15_DWORD_WIDTH + 2 + 4;
  localparam int ret_w_lp = 4 + 1 + 1 + 4 * `L15_DWORD_WIDTH;

  // Encodings as seen on the L1.5 wires
  localparam logic [4:0] rq_load_lp  = 5'b00000;
  localparam logic [4:0] rq_store_lp = 5'b00001;
  localparam logic [4:0] rq_imiss_lp = 5'b10000;
  localparam logic [3:0] rt_load_lp  = 4'b0000;
  localparam logic [3:0] rt_ifill_lp = 4'b0001;
  localparam logic [3:0] rt_st_lp    = 4'b0100;

  typedef struct {
    string       name;
    int          n_icache;
    int          n_dcache;
    int          hold;
    int          n_ret;
    logic [31:0] ret_types;
    bit          prefer_d;
  } test_row_t;

  logic clk_i, arst_n_i;
  logic icache_req_v_i, icache_req_nc_i, icache_req_ready_o;
  logic [4:0] icache_req_rqtype_i;
  logic [2:0] icache_req_size_i;
  logic [`L15_PADDR_WIDTH-1:0] icache_req_address_i;
  logic [`L15_DWORD_WIDTH-1:0] icache_req_data_i;
  logic [1:0] icache_req_l1rplway_i;
  logic [3:0] icache_req_amo_op_i;
  logic dcache_req_v_i, dcache_req_nc_i, dcache_req_ready_o;
  logic [4:0] dcache_req_rqtype_i;
  logic [2:0] dcache_req_size_i;
  logic [`L15_PADDR_WIDTH-1:0] dcache_req_address_i;
  logic [`L15_DWORD_WIDTH-1:0] dcache_req_data_i;
  logic [1:0] dcache_req_l1rplway_i;
  logic [3:0] dcache_req_amo_op_i;
  logic transducer_l15_val_o, transducer_l15_nc_o, l15_transducer_ack_i;
  logic [4:0] transducer_l15_rqtype_o;
  logic [2:0] transducer_l15_size_o;
  logic [`L15_PADDR_WIDTH-1:0] transducer_l15_address_o;
  logic [`L15_DWORD_WIDTH-1:0] transducer_l15_data_o;
  logic [1:0] transducer_l15_l1rplway_o;
  logic [3:0] transducer_l15_amo_op_o;
  logic l15_transducer_val_i, l15_transducer_noncacheable_i, l15_transducer_atomic_i;
  logic [3:0] l15_transducer_returntype_i;
  logic [`L15_DWORD_WIDTH-1:0] l15_transducer_data_0_i, l15_transducer_data_1_i;
  logic [`L15_DWORD_WIDTH-1:0] l15_transducer_data_2_i, l15_transducer_data_3_i;
  logic transducer_l15_req_ack_o;
  logic [3:0] ret_rtntype_o;
  logic ret_noncacheable_o, ret_atomic_o;
  logic [`L15_DWORD_WIDTH-1:0] ret_data_0_o, ret_data_1_o, ret_data_2_o, ret_data_3_o;
  logic icache_ret_v_o, dcache_ret_v_o, icache_ret_yumi_i, dcache_ret_yumi_i;

  l15_bridge_top uut (.*);

  test_row_t rows [7];
  integer seed = 80151;
  int errors = 0;
  string cur_name;
  logic [req_w_lp-1:0] iq [$];
  logic [req_w_lp-1:0] dq [$];
  logic [ret_w_lp-1:0] rq [$];

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [req_w_lp-1:0] make_req(input logic [4:0] rqtype);
    logic [63:0] addr_r, data_r;
    addr_r = {$random(seed), $random(seed)};
    data_r = {$random(seed), $random(seed)};
    return {rqtype, data_r[0], data_r[3:1], addr_r[`L15_PADDR_WIDTH-1:0], data_r,
            addr_r[41:40], addr_r[47:44]};
  endfunction

  function automatic logic [ret_w_lp-1:0] make_ret(input logic [3:0] rtntype);
    logic [63:0] w0, w1, w2, w3;
    w0 = {$random(seed), $random(seed)};
    w1 = {$random(seed), $random(seed)};
    w2 = {$random(seed), $random(seed)};
    w3 = {$random(seed), $random(seed)};
    return {rtntype, w0[63], w1[63], w0, w1, w2, w3};
  endfunction

  function automatic logic [req_w_lp-1:0] bus_word();
    return {transducer_l15_rqtype_o, transducer_l15_nc_o, transducer_l15_size_o,
            transducer_l15_address_o, transducer_l15_data_o,
            transducer_l15_l1rplway_o, transducer_l15_amo_op_o};
  endfunction

  function automatic logic [ret_w_lp-1:0] ret_word();
    return {ret_rtntype_o, ret_noncacheable_o, ret_atomic_o,
            ret_data_0_o, ret_data_1_o, ret_data_2_o, ret_data_3_o};
  endfunction

  task automatic check_eq(input string what, input logic [ret_w_lp-1:0] exp,
                          input logic [ret_w_lp-1:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_valid(input string what, input logic exp, input logic act);
    if (exp && act !== 1'b1) begin
      $display("%s: %s stayed low although an entry was pending", cur_name, what);
      errors++;
    end
    if (!exp && act !== 1'b0) begin
      $display("%s: %s was high with nothing pending", cur_name, what);
      errors++;
    end
  endtask

  task automatic run_requests(input test_row_t row);
    int n;
    logic [req_w_lp-1:0] iw, dw, head;
    logic exp_v;
    n = (row.n_icache > row.n_dcache) ? row.n_icache : row.n_dcache;
    // Ack held low while the queues fill
    for (int c = 0; c < n; c++) begin
      @(posedge clk_i);
      iw = make_req(rq_imiss_lp);
      dw = make_req(iw[100] ? rq_store_lp : rq_load_lp);
      icache_req_v_i <= (c < row.n_icache);
      dcache_req_v_i <= (c < row.n_dcache);
      {icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i, icache_req_address_i,
       icache_req_data_i, icache_req_l1rplway_i, icache_req_amo_op_i} <= iw;
      {dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i, dcache_req_address_i,
       dcache_req_data_i, dcache_req_l1rplway_i, dcache_req_amo_op_i} <= dw;
      @(negedge clk_i);
      check_eq("icache ready", ret_w_lp'(iq.size() < `L15_REQ_FIFO_ELS),
               ret_w_lp'(icache_req_ready_o));
      check_eq("dcache ready", ret_w_lp'(dq.size() < `L15_REQ_FIFO_ELS),
               ret_w_lp'(dcache_req_ready_o));
      // Only requests accepted at earlier edges may be on the bus
      exp_v = (iq.size() + dq.size()) > 0;
      check_valid("bus valid", exp_v, transducer_l15_val_o);
      if (c < row.n_icache && icache_req_ready_o) iq.push_back(iw);
      if (c < row.n_dcache && dcache_req_ready_o) dq.push_back(dw);
    end
    if (n > 0) begin
      @(posedge clk_i);
      icache_req_v_i <= 1'b0;
      dcache_req_v_i <= 1'b0;
    end
    // Bus must hold steady without ack
    for (int h = 0; h < row.hold; h++) begin
      @(negedge clk_i);
      exp_v = (iq.size() + dq.size()) > 0;
      check_valid("bus valid", exp_v, transducer_l15_val_o);
      head = (dq.size() > 0) ? dq[0] : ((iq.size() > 0) ? iq[0] : '0);
      if (exp_v) check_eq("bus fields", ret_w_lp'(head), ret_w_lp'(bus_word()));
    end
    @(posedge clk_i);
    l15_transducer_ack_i <= 1'b1;
    forever begin
      @(negedge clk_i);
      exp_v = (iq.size() + dq.size()) > 0;
      check_valid("bus valid", exp_v, transducer_l15_val_o);
      if (!exp_v) break;
      if (dq.size() > 0) begin
        check_eq("bus fields", ret_w_lp'(dq[0]), ret_w_lp'(bus_word()));
        void'(dq.pop_front());
      end else begin
        check_eq("bus fields", ret_w_lp'(iq[0]), ret_w_lp'(bus_word()));
        void'(iq.pop_front());
      end
    end
    @(posedge clk_i);
    l15_transducer_ack_i <= 1'b0;
  endtask

  // Checks the head and takes it from one side
  task automatic consume_one(input bit prefer_d);
    logic [3:0] t;
    logic exp_i, exp_d, take_d;
    t = rq[0][ret_w_lp-1 -: 4];
    exp_i = (t != rt_load_lp) && (t != rt_st_lp);
    exp_d = (t != rt_ifill_lp);
    check_valid("icache return valid", exp_i, icache_ret_v_o);
    check_valid("dcache return valid", exp_d, dcache_ret_v_o);
    check_eq("return fields", rq[0], ret_word());
    take_d = prefer_d ? exp_d : !exp_i;
    @(posedge clk_i);
    icache_ret_yumi_i <= !take_d;
    dcache_ret_yumi_i <= take_d;
    @(posedge clk_i);
    icache_ret_yumi_i <= 1'b0;
    dcache_ret_yumi_i <= 1'b0;
    void'(rq.pop_front());
  endtask

  task automatic run_returns(input test_row_t row);
    logic [ret_w_lp-1:0] w;
    bit accepted;
    int stall;
    for (int i = 0; i < row.n_ret; i++) begin
      w = make_ret(row.ret_types[(i % 8) * 4 +: 4]);
      @(posedge clk_i);
      l15_transducer_val_i <= 1'b1;
      {l15_transducer_returntype_i, l15_transducer_noncacheable_i, l15_transducer_atomic_i,
       l15_transducer_data_0_i, l15_transducer_data_1_i, l15_transducer_data_2_i,
       l15_transducer_data_3_i} <= w;
      accepted = 0;
      stall = 0;
      while (!accepted) begin
        @(negedge clk_i);
        // An empty queue shows nothing before the enqueue edge
        if (rq.size() == 0) begin
          check_valid("icache return valid", 1'b0, icache_ret_v_o);
          check_valid("dcache return valid", 1'b0, dcache_ret_v_o);
        end
        check_eq("return ack", ret_w_lp'(rq.size() < `L15_RET_FIFO_ELS),
                 ret_w_lp'(transducer_l15_req_ack_o));
        if (transducer_l15_req_ack_o) begin
          rq.push_back(w);
          accepted = 1;
        end else begin
          stall++;
          if (stall == 3 && rq.size() > 0) consume_one(row.prefer_d);
          if (stall > 20) begin
            $display("%s: return %0d was never acknowledged", cur_name, i);
            errors++;
            accepted = 1;
          end
        end
      end
    end
    if (row.n_ret > 0) begin
      @(posedge clk_i);
      l15_transducer_val_i <= 1'b0;
    end
    while (rq.size() > 0) begin
      @(negedge clk_i);
      consume_one(row.prefer_d);
    end
    @(negedge clk_i);
    check_valid("icache return valid", 1'b0, icache_ret_v_o);
    check_valid("dcache return valid", 1'b0, dcache_ret_v_o);
  endtask

  initial begin
    int limit, err_before, n_pass, n_fail;
    {icache_req_v_i, icache_req_rqtype_i, icache_req_nc_i, icache_req_size_i} <= '0;
    {icache_req_address_i, icache_req_data_i, icache_req_l1rplway_i} <= '0;
    {dcache_req_v_i, dcache_req_rqtype_i, dcache_req_nc_i, dcache_req_size_i} <= '0;
    {dcache_req_address_i, dcache_req_data_i, dcache_req_l1rplway_i} <= '0;
    {icache_req_amo_op_i, dcache_req_amo_op_i, l15_transducer_ack_i} <= '0;
    {l15_transducer_val_i, l15_transducer_returntype_i} <= '0;
    {l15_transducer_noncacheable_i, l15_transducer_atomic_i} <= '0;
    {l15_transducer_data_0_i, l15_transducer_data_1_i} <= '0;
    {l15_transducer_data_2_i, l15_transducer_data_3_i} <= '0;
    {icache_ret_yumi_i, dcache_ret_yumi_i} <= '0;
    arst_n_i <= 1'b0;
    rows[0] = '{"single_imiss", 1, 0, 1, 0, 32'h0, 1'b0};
    rows[1] = '{"both_engines", 2, 2, 1, 0, 32'h0, 1'b0};
    rows[2] = '{"ack_stall", 3, 0, 4, 0, 32'h0, 1'b0};
    rows[3] = '{"single_return", 0, 0, 1, 1, 32'h1, 1'b0};
    rows[4] = '{"steer_icache_first", 0, 0, 1, 6, 32'h00D74310, 1'b0};
    rows[5] = '{"steer_dcache_first", 0, 0, 1, 6, 32'h00D74310, 1'b1};
    rows[6] = '{"return_overflow", 0, 0, 1, 17, 32'h1D740314, 1'b1};
    limit = 20;
    foreach (rows[r]) begin
      limit += 3 * (rows[r].n_icache + rows[r].n_dcache) + rows[r].hold
               + 5 * rows[r].n_ret + 20;
    end
    limit = limit * 4 * 3;
    fork
      begin
        #(limit);
        $display("Timeout: run did not finish within %0d time units", limit);
        $display("CHECKS FAILED");
        $finish;
      end
    join_none

    repeat (10) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    cur_name = "after_reset";
    check_valid("bus valid", 1'b0, transducer_l15_val_o);
    check_valid("icache return valid", 1'b0, icache_ret_v_o);
    check_valid("dcache return valid", 1'b0, dcache_ret_v_o);
    check_eq("request readies", ret_w_lp'(2'b11),
             ret_w_lp'({icache_req_ready_o, dcache_req_ready_o}));
    n_pass = (errors == 0) ? 1 : 0;
    n_fail = 1 - n_pass;
    $display("test %s: %s", cur_name, (errors == 0) ? "ok" : "failed");

    foreach (rows[r]) begin
      cur_name = rows[r].name;
      err_before = errors;
      run_requests(rows[r]);
      run_returns(rows[r]);
      if (errors == err_before) begin
        n_pass++;
        $display("test %s: ok", cur_name);
      end else begin
        n_fail++;
        $display("test %s: failed with %0d errors", cur_name, errors - err_before);
      end
    end

    $display("tests passed %0d, tests failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/l15_pkg.sv
design/l15_fifo.sv
l15_bridge/l15_req_arbiter.sv
l15_bridge/l15_ret_router.sv
l15_bridge/l15_bridge_top.sv
tests/tb_l15_bridge.sv

/* Makefile */
# Verilator build and run for the L1.5 bridge testbench

TOP := tb_l15_bridge
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "CHECKS FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then exit $$status; fi

clean:
	rm -rf obj_dir $(LOG)
